//--- include/subst_config.svh
`ifndef SUBST_CONFIG_SVH
`define SUBST_CONFIG_SVH

// datapath geometry.
`define SUBST_LANES 4
`define SUBST_ELEM_W 6
`define SUBST_WORD_W 24

// register map.
`define SUBST_ADDR_KEY 0
`define SUBST_ADDR_MODE 1

// address width of the register port.
`define SUBST_ADDR_W 2

`endif

//--- source/ctrl_pkg.sv
`include "subst_config.svh"

package ctrl_pkg;

  typedef logic [`SUBST_ADDR_W-1:0] reg_addr_t;

  // register addresses.
  localparam reg_addr_t addr_key  = `SUBST_ADDR_KEY;
  localparam reg_addr_t addr_mode = `SUBST_ADDR_MODE;

  // engine operating mode.
  typedef enum logic {
    mode_sbox   = 1'b0,
    mode_bypass = 1'b1
  } mode_t;

endpackage

//--- source/field_pkg.sv
`include "subst_config.svh"

package field_pkg;

  // one gf(4) digit, polynomial form over gf(2).
  typedef logic [1:0] gf4_t;

  // three gf(4) digits, d0 in the low bits.
  typedef struct packed {
    gf4_t d2;
    gf4_t d1;
    gf4_t d0;
  } gf64_tower_t;

  // a gf(2^6) element in either basis.
  typedef union packed {
    logic [`SUBST_ELEM_W-1:0] bits;
    gf64_tower_t              tower;
  } gf64_t;

endpackage

//--- source/gf64_basis_change.sv
`timescale 1ns/1ns

module gf64_basis_change (
  input  field_pkg::gf64_t to_tower,
  output field_pkg::gf64_t tower,
  input  field_pkg::gf64_t from_tower,
  output field_pkg::gf64_t poly
);

  logic [5:0] p;
  logic [5:0] f;

  assign p = to_tower.bits;
  assign f = from_tower.bits;

  // polynomial basis into the tower digits.
  always_comb begin
    tower.tower.d0 = {p[4], p[0] ^ p[4] ^ p[5]};
    tower.tower.d1 = {p[1] ^ p[2] ^ p[3] ^ p[5], p[0] ^ p[3]};
    tower.tower.d2 = {p[1] ^ p[2] ^ p[4] ^ p[5], p[0] ^ p[1]};
  end

  // inverse map back to the polynomial basis.
  assign poly.bits = {
    f[0] ^ f[2] ^ f[3] ^ f[5],
    f[1],
    f[1] ^ f[3] ^ f[5],
    f[0] ^ f[4] ^ f[5],
    f[1] ^ f[2] ^ f[3] ^ f[4] ^ f[5],
    f[1] ^ f[2] ^ f[3] ^ f[5]
  };

endmodule

//--- source/gf64_power41.sv
`timescale 1ns/1ns

module gf64_power41 (
  input  field_pkg::gf64_t a,
  output field_pkg::gf64_t b
);

  // frobenius in gf(4).
  function automatic field_pkg::gf4_t gf4_sq(input field_pkg::gf4_t v);
    gf4_sq = {v[1], v[0] ^ v[1]};
  endfunction

  function automatic field_pkg::gf4_t gf4_mul(input field_pkg::gf4_t u,
                                              input field_pkg::gf4_t v);
    logic t;
    t = u[1] & v[1];
    gf4_mul = {(u[0] & v[1]) ^ (u[1] & v[0]) ^ t, (u[0] & v[0]) ^ t};
  endfunction

  // u^3 is one for any nonzero digit, so this scales v by u^3.
  function automatic field_pkg::gf4_t gf4_cube_scale(input field_pkg::gf4_t u,
                                                     input field_pkg::gf4_t v);
    gf4_cube_scale = (u[0] | u[1]) ? v : 2'b00;
  endfunction

  field_pkg::gf4_t y0, y1, y2;
  field_pkg::gf4_t sq0, sq1, sq2;
  field_pkg::gf4_t cs_1_0, cs_2_0, cs_0_1, cs_2_1, cs_0_2, cs_1_2;
  field_pkg::gf4_t p01, p02, p12;
  field_pkg::gf4_t t0, t1, t2;
  field_pkg::gf4_t out0, out1, out2;

  assign y0 = a.tower.d0;
  assign y1 = a.tower.d1;
  assign y2 = a.tower.d2;

  assign sq0 = gf4_sq(y0);
  assign sq1 = gf4_sq(y1);
  assign sq2 = gf4_sq(y2);

  // cube-scaled squares.
  assign cs_1_0 = gf4_cube_scale(y1, sq0);
  assign cs_2_0 = gf4_cube_scale(y2, sq0);
  assign cs_0_1 = gf4_cube_scale(y0, sq1);
  assign cs_2_1 = gf4_cube_scale(y2, sq1);
  assign cs_0_2 = gf4_cube_scale(y0, sq2);
  assign cs_1_2 = gf4_cube_scale(y1, sq2);

  // pairwise products.
  assign p01 = gf4_mul(y0, y1);
  assign p02 = gf4_mul(y0, y2);
  assign p12 = gf4_mul(y1, y2);

  // triple terms, each digit times the other two squared.
  assign t0 = gf4_mul(y0, gf4_mul(sq1, sq2));
  assign t1 = gf4_mul(y1, gf4_mul(sq0, sq2));
  assign t2 = gf4_mul(y2, gf4_mul(sq0, sq1));

  assign out0 = sq0 ^ sq1 ^ cs_1_0 ^ cs_2_0 ^ cs_1_2 ^ p01 ^ p02 ^ t0 ^ t2;
  assign out1 = sq1 ^ sq2 ^ cs_2_0 ^ cs_0_1 ^ cs_2_1 ^ p01 ^ p12 ^ t0 ^ t1;
  assign out2 = sq0 ^ sq2 ^ cs_0_1 ^ cs_0_2 ^ cs_1_2 ^ p02 ^ p12 ^ t1 ^ t2;

  assign b.tower = '{d2: out2, d1: out1, d0: out0};

endmodule

//--- source/sbox6_core.sv
`timescale 1ns/1ns
`include "subst_config.svh"

module sbox6_core (
  input  logic [`SUBST_ELEM_W-1:0] x,
  output logic [`SUBST_ELEM_W-1:0] y
);

  field_pkg::gf64_t x_poly;
  field_pkg::gf64_t x_tower;
  field_pkg::gf64_t y_tower;
  field_pkg::gf64_t y_poly;
  logic             affine;

  assign x_poly.bits = x;

  gf64_basis_change u_basis (
    .to_tower  (x_poly),
    .tower     (x_tower),
    .from_tower(y_tower),
    .poly      (y_poly)
  );

  gf64_power41 u_power (
    .a(x_tower),
    .b(y_tower)
  );

  // affine correction from input bits 2 and 4.
  assign affine = x[2] ^ x[4];
  assign y = y_poly.bits ^ {`SUBST_ELEM_W{affine}};

endmodule

//--- source/subst_engine.sv
`timescale 1ns/1ns
`include "subst_config.svh"

module subst_engine (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`SUBST_WORD_W-1:0] in_data,
  input  logic                     req,
  output logic [`SUBST_WORD_W-1:0] out_data,
  output logic                     ack,
  input  logic                     reg_wr,
  input  ctrl_pkg::reg_addr_t      reg_addr,
  input  logic [`SUBST_WORD_W-1:0] reg_wdata,
  output logic [`SUBST_WORD_W-1:0] reg_rdata
);

  logic [`SUBST_WORD_W-1:0] key;
  ctrl_pkg::mode_t          mode;

  subst_regs u_regs (
    .clk      (clk),
    .rst      (rst),
    .reg_wr   (reg_wr),
    .reg_addr (reg_addr),
    .reg_wdata(reg_wdata),
    .reg_rdata(reg_rdata),
    .key      (key),
    .mode     (mode)
  );

  subst_layer u_layer (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .in_data (in_data),
    .key     (key),
    .mode    (mode),
    .ack     (ack),
    .out_data(out_data)
  );

endmodule

//--- source/subst_layer.sv
`timescale 1ns/1ns
`include "subst_config.svh"

module subst_layer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req,
  input  logic [`SUBST_WORD_W-1:0] in_data,
  input  logic [`SUBST_WORD_W-1:0] key,
  input  ctrl_pkg::mode_t          mode,
  output logic                     ack,
  output logic [`SUBST_WORD_W-1:0] out_data
);

  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_capture = 2'd1;
  localparam logic [1:0] st_respond = 2'd2;
  localparam logic [1:0] st_release = 2'd3;

  logic [1:0]               state;
  logic                     accept;
  logic [`SUBST_WORD_W-1:0] mixed_q;
  ctrl_pkg::mode_t          mode_q;
  logic [`SUBST_WORD_W-1:0] sbox_word;

  // release also accepts, so a back-to-back req is not delayed.
  assign accept = req && (state == st_idle || state == st_release);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      ack      <= 1'b0;
      out_data <= '0;
    end else begin
      case (state)
        st_idle, st_release: begin
          state <= accept ? st_capture : st_idle;
        end
        st_capture: begin
          state    <= st_respond;
          ack      <= 1'b1;
          out_data <= (mode_q == ctrl_pkg::mode_bypass) ? mixed_q : sbox_word;
        end
        st_respond: begin
          // hold ack and data until the host drops req.
          if (!req) begin
            ack   <= 1'b0;
            state <= st_release;
          end
        end
      endcase
    end
  end

  // key and mode sampled at acceptance.
  always_ff @(posedge clk) begin
    if (accept) begin
      mixed_q <= in_data ^ key;
      mode_q  <= mode;
    end
  end

  for (genvar i = 0; i < `SUBST_LANES; i++) begin : g_lane
    sbox6_core u_sbox (
      .x(mixed_q[i*`SUBST_ELEM_W +: `SUBST_ELEM_W]),
      .y(sbox_word[i*`SUBST_ELEM_W +: `SUBST_ELEM_W])
    );
  end

endmodule

//--- source/subst_regs.sv
`timescale 1ns/1ns
`include "subst_config.svh"

module subst_regs (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     reg_wr,
  input  ctrl_pkg::reg_addr_t      reg_addr,
  input  logic [`SUBST_WORD_W-1:0] reg_wdata,
  output logic [`SUBST_WORD_W-1:0] reg_rdata,
  output logic [`SUBST_WORD_W-1:0] key,
  output ctrl_pkg::mode_t          mode
);

  always_ff @(posedge clk) begin
    if (rst) begin
      key  <= '0;
      mode <= ctrl_pkg::mode_sbox;
    end else if (reg_wr) begin
      case (reg_addr)
        ctrl_pkg::addr_key:  key <= reg_wdata;
        // only bit 0 is kept.
        ctrl_pkg::addr_mode: mode <= ctrl_pkg::mode_t'(reg_wdata[0]);
        default: ;
      endcase
    end
  end

  // unmapped addresses read as zero.
  always_comb begin
    reg_rdata = '0;
    case (reg_addr)
      ctrl_pkg::addr_key:  reg_rdata = key;
      ctrl_pkg::addr_mode: reg_rdata[0] = mode;
      default: ;
    endcase
  end

endmodule

//--- subst_engine.f
+incdir+include
source/field_pkg.sv
source/ctrl_pkg.sv
source/gf64_basis_change.sv
source/gf64_power41.sv
source/sbox6_core.sv
source/subst_regs.sv
source/subst_layer.sv
source/subst_engine.sv
test/clock_gen.sv
test/subst_engine_props.sv
test/subst_engine_tb.sv

//--- test/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reset held for four clock cycles.
  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- test/subst_engine_props.sv
`timescale 1ns/1ns
`include "subst_config.svh"

module subst_engine_props (
  input logic                     clk,
  input logic                     rst,
  input logic                     req,
  input logic                     ack,
  input logic [`SUBST_WORD_W-1:0] out_data
);

  int fail_count = 0;

  // capture cycle, then ack.
  ack_rise: assert property (@(posedge clk) disable iff (rst) $rose(req) |-> ##2 $rose(ack))
    else begin
      fail_count++;
      $error("ack did not rise two cycles after req");
    end

  data_hold: assert property (@(posedge clk) disable iff (rst)
    (ack && $past(ack)) |-> $stable(out_data))
    else begin
      fail_count++;
      $error("out_data changed while ack was high");
    end

  ack_fall: assert property (@(posedge clk) disable iff (rst) $fell(req) |-> ##1 $fell(ack))
    else begin
      fail_count++;
      $error("ack did not fall one cycle after req");
    end

  reset_ack: assert property (@(posedge clk) rst |=> !ack)
    else begin
      fail_count++;
      $error("ack high during or just after reset");
    end

endmodule

//--- test/subst_engine_tb.sv
`timescale 1ns/1ns
`include "subst_config.svh"

module subst_engine_tb;

  logic                     clk;
  logic                     rst;
  logic [`SUBST_WORD_W-1:0] in_data;
  logic                     req;
  logic [`SUBST_WORD_W-1:0] out_data;
  logic                     ack;
  logic                     reg_wr;
  ctrl_pkg::reg_addr_t      reg_addr;
  logic [`SUBST_WORD_W-1:0] reg_wdata;
  logic [`SUBST_WORD_W-1:0] reg_rdata;

  int seed = 15466;
  int check_errors = 0;
  int timeout_errors = 0;

  clock_gen u_clk (
    .clk(clk),
    .rst(rst)
  );

  subst_engine uut (
    .clk      (clk),
    .rst      (rst),
    .in_data  (in_data),
    .req      (req),
    .out_data (out_data),
    .ack      (ack),
    .reg_wr   (reg_wr),
    .reg_addr (reg_addr),
    .reg_wdata(reg_wdata),
    .reg_rdata(reg_rdata)
  );

  bind subst_engine subst_engine_props props (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .ack     (ack),
    .out_data(out_data)
  );

  task automatic check_word(input string name, input logic [`SUBST_WORD_W-1:0] exp,
                            input logic [`SUBST_WORD_W-1:0] act);
    assert (act === exp)
    else begin
      check_errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    @(posedge clk);
    while (ack !== level && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (ack !== level) begin
      timeout_errors++;
      $display("timeout: ack did not go to %0b within 20 cycles", level);
    end
  endtask

  task automatic write_reg(input ctrl_pkg::reg_addr_t addr, input logic [`SUBST_WORD_W-1:0] d);
    @(posedge clk);
    reg_wr    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= d;
    @(posedge clk);
    reg_wr <= 1'b0;
  endtask

  task automatic read_reg(input ctrl_pkg::reg_addr_t addr, output logic [`SUBST_WORD_W-1:0] d);
    @(posedge clk);
    reg_addr <= addr;
    @(posedge clk);
    d = reg_rdata;
  endtask

  // full four-phase transaction, req held for extra cycles.
  task automatic run_txn(input logic [`SUBST_WORD_W-1:0] d, input int hold,
                         output logic [`SUBST_WORD_W-1:0] q);
    @(posedge clk);
    in_data <= d;
    req     <= 1'b1;
    wait_ack(1'b1);
    q = out_data;
    repeat (hold) @(posedge clk);
    req <= 1'b0;
    wait_ack(1'b0);
  endtask

  initial begin
    logic [`SUBST_WORD_W-1:0] r1;
    logic [`SUBST_WORD_W-1:0] r2;
    logic [`SUBST_WORD_W-1:0] d;
    logic [`SUBST_WORD_W-1:0] k;
    logic [`SUBST_WORD_W-1:0] k_new;
    logic [`SUBST_ELEM_W-1:0] v;
    int n;
    in_data   = '0;
    req       = 1'b0;
    reg_wr    = 1'b0;
    reg_addr  = ctrl_pkg::addr_key;
    reg_wdata = '0;
    n = 0;
    while (rst !== 1'b0 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      timeout_errors++;
      $display("timeout: reset was not released within 20 cycles");
    end
    check_word("reset_out", '0, out_data);
    read_reg(ctrl_pkg::addr_mode, r1);
    check_word("reset_mode", '0, r1);
    run_txn('0, 0, r1);
    check_word("zero", '0, r1);
    // back-pressure.
    run_txn($random(seed), 10, r1);
    repeat (8) begin
      v = $random(seed);
      run_txn({`SUBST_LANES{v}}, 0, r1);
      for (int i = 1; i < `SUBST_LANES; i++) begin
        check_word("lanes", r1[`SUBST_ELEM_W-1:0], r1[i*`SUBST_ELEM_W +: `SUBST_ELEM_W]);
      end
    end
    repeat (6) begin
      d = $random(seed);
      k = $random(seed);
      write_reg(ctrl_pkg::addr_key, k);
      read_reg(ctrl_pkg::addr_key, r2);
      check_word("key_readback", k, r2);
      run_txn(d, 0, r1);
      write_reg(ctrl_pkg::addr_key, '0);
      run_txn(d ^ k, 0, r2);
      check_word("key_mix", r1, r2);
    end
    write_reg(ctrl_pkg::addr_mode, 24'h1);
    read_reg(ctrl_pkg::addr_mode, r1);
    check_word("mode_readback", 24'h1, r1);
    repeat (4) begin
      d = $random(seed);
      k = $random(seed);
      write_reg(ctrl_pkg::addr_key, k);
      run_txn(d, 0, r1);
      check_word("bypass", d ^ k, r1);
    end
    // new key lands on the acceptance edge.
    d = $random(seed);
    k_new = $random(seed);
    fork
      run_txn(d, 3, r1);
      write_reg(ctrl_pkg::addr_key, k_new);
    join
    check_word("key_mid_txn", d ^ k, r1);
    run_txn(d, 0, r2);
    check_word("key_next_txn", d ^ k_new, r2);
    repeat (2) @(posedge clk);
    $display("errors: checks %0d, timeouts %0d, assertions %0d",
             check_errors, timeout_errors, uut.props.fail_count);
    if (check_errors + timeout_errors + uut.props.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
